/* arp_pkg.sv */
// ================================================
// Shared types and protocol constants for the ARP
// receive scanner. Every design file imports this
// package with a wildcard import in its header.
// ================================================

package arp_pkg;

	// One GMII octet
	typedef logic [7:0] octet_t;
	// Octet index inside a frame, also the frame length
	typedef logic [10:0] frame_cnt_t;
	// Address into the MAC/IP configuration memory
	typedef logic [3:0] cfg_addr_t;
	// Frame summary, see STAT_* bit positions
	typedef logic [3:0] status_t;

	// Receive framing states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_DATA,
		ST_DROP
	} rx_state_t;

	// GMII framing octets
	localparam octet_t PREAMBLE_OCTET = 8'h55;
	localparam octet_t SFD_OCTET = 8'hd5;
	localparam octet_t BCAST_OCTET = 8'hff;

	// Gap rules, counter saturates a little above the minimum
	localparam logic [3:0] IFG_MIN = 4'd10;
	localparam logic [3:0] IFG_SAT = 4'd12;
	// Longest frame accepted, counted after the SFD
	localparam frame_cnt_t MAX_FRAME = 11'd1536;

	// Reflected Ethernet CRC32 and the residue left after the FCS
	localparam logic [31:0] CRC_POLY = 32'hedb88320;
	localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

	// Config memory layout: MAC at 0..5, IP at 6..9
	localparam cfg_addr_t CFG_MAC_BASE = 4'd0;
	localparam cfg_addr_t CFG_IP_BASE = 4'd6;

	// Frame layout
	localparam frame_cnt_t MAC_LEN = 11'd6;
	localparam frame_cnt_t SRC_MAC_FIRST = 11'd6;
	localparam frame_cnt_t ARP_TEMPLATE_FIRST = 11'd12;
	localparam frame_cnt_t ARP_TEMPLATE_LAST = 11'd21;
	localparam frame_cnt_t ARP_TIP_FIRST = 11'd38;
	localparam frame_cnt_t ARP_TIP_LEN = 11'd4;

	// Bit positions in status_t
	localparam int STAT_CRC = 0;
	localparam int STAT_MAC = 1;
	localparam int STAT_ARP = 2;
	localparam int STAT_ACCEPT = 3;

endpackage

/* frame_sync.sv */
// ================================================
// GMII frame front end. Tracks preamble, SFD and the
// inter-frame gap, then hands each data octet on as
// a registered stream with index, first and end marks.
// ================================================
`timescale 1ns/100ps

module frame_sync
	import arp_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  octet_t     eth_in,
	input  logic       eth_in_s,
	input  logic       enable_rx,
	output octet_t     rx_data,
	output logic       rx_valid,
	output logic       rx_first,
	output frame_cnt_t rx_cnt,
	output logic       rx_end
);

	rx_state_t  state;
	logic [3:0] ifg_cnt;
	logic       en_meta;
	logic       en_sync;
	frame_cnt_t oct_cnt;
	logic       ifg_ok;
	logic       take;
	logic       too_long;

	assign ifg_ok = ifg_cnt >= IFG_MIN;
	// Octet accepted into the stream
	assign take = (state == ST_DATA) && eth_in_s && (oct_cnt != MAX_FRAME);
	// One octet past the limit
	assign too_long = (state == ST_DATA) && eth_in_s && (oct_cnt == MAX_FRAME);

	// Enable comes from another clock domain
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			en_meta <= 1'b0;
			en_sync <= 1'b0;
		end else begin
			en_meta <= enable_rx;
			en_sync <= en_meta;
		end
	end

	// Gap counter
	// Counts strobe-low cycles, cleared by frame octets
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ifg_cnt <= '0;
		end else if (!eth_in_s) begin
			if (ifg_cnt != IFG_SAT)
				ifg_cnt <= ifg_cnt + 1'b1;
		end else if (state == ST_DATA || state == ST_DROP) begin
			ifg_cnt <= '0;
		end
	end

	// Frame FSM
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					// Reception must be enabled at frame start
					if (eth_in_s) begin
						if (eth_in == PREAMBLE_OCTET && en_sync)
							state <= ST_PREAMBLE;
						else
							state <= ST_DROP;
					end
				end
				ST_PREAMBLE: begin
					if (!eth_in_s)
						state <= ST_IDLE;
					else if (eth_in == SFD_OCTET)
						state <= ifg_ok ? ST_DATA : ST_DROP;
					else if (eth_in != PREAMBLE_OCTET)
						state <= ST_DROP;
				end
				ST_DATA: begin
					if (!eth_in_s)
						state <= ST_IDLE;
					else if (too_long)
						state <= ST_DROP;
				end
				default: begin
					// Wait out the rest of a dropped frame
					if (!eth_in_s)
						state <= ST_IDLE;
				end
			endcase
		end
	end

	// Stream control marks
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			oct_cnt  <= '0;
			rx_valid <= 1'b0;
			rx_first <= 1'b0;
			rx_end   <= 1'b0;
		end else begin
			oct_cnt  <= take ? oct_cnt + 1'b1 : '0;
			rx_valid <= take;
			rx_first <= take && (oct_cnt == '0);
			// Strobe fell during data, frame completed normally
			rx_end   <= (state == ST_DATA) && !eth_in_s;
		end
	end

	// Octet and index held between valid cycles
	always_ff @(posedge clk) begin
		if (take) begin
			rx_data <= eth_in;
			rx_cnt  <= oct_cnt;
		end
	end

endmodule

/* arp_header_check.sv */
// ================================================
// Header matcher. Compares destination MAC and ARP
// target IP with the config memory, checks the ARP
// request template and the source MAC unicast bit.
// ================================================
`timescale 1ns/100ps

module arp_header_check
	import arp_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  octet_t     rx_data,
	input  logic       rx_valid,
	input  logic       rx_first,
	input  frame_cnt_t rx_cnt,
	output cfg_addr_t  cfg_addr,
	input  octet_t     cfg_data,
	output logic       mac_match,
	output logic       arp_ok,
	output logic       src_unicast
);

	frame_cnt_t nxt_cnt;
	frame_cnt_t nxt_tip_off;
	frame_cnt_t tpl_idx;
	logic       nxt_in_tip;
	logic       in_mac;
	logic       in_tpl;
	logic       in_tip;
	logic       cfg_hit;
	octet_t     tpl_octet;
	logic       uc_ok;
	logic       bc_ok;
	logic       tpl_ok;
	logic       tip_ok;
	logic       tip_seen;

	// Index of the octet that arrives next
	// Memory data then lines up with it
	assign nxt_cnt = rx_valid ? rx_cnt + 1'b1 : '0;
	assign nxt_tip_off = nxt_cnt - ARP_TIP_FIRST;
	assign nxt_in_tip = (nxt_cnt >= ARP_TIP_FIRST) && (nxt_cnt < ARP_TIP_FIRST + ARP_TIP_LEN);

	always_comb begin
		if (nxt_cnt < MAC_LEN)
			cfg_addr = CFG_MAC_BASE + cfg_addr_t'(nxt_cnt);
		else if (nxt_in_tip)
			cfg_addr = CFG_IP_BASE + cfg_addr_t'(nxt_tip_off);
		else
			cfg_addr = CFG_MAC_BASE;
	end

	// Windows for the current octet
	assign in_mac = rx_cnt < MAC_LEN;
	assign in_tpl = (rx_cnt >= ARP_TEMPLATE_FIRST) && (rx_cnt <= ARP_TEMPLATE_LAST);
	assign in_tip = (rx_cnt >= ARP_TIP_FIRST) && (rx_cnt < ARP_TIP_FIRST + ARP_TIP_LEN);
	assign cfg_hit = rx_data == cfg_data;

	// ARP request template, offset from EtherType
	assign tpl_idx = rx_cnt - ARP_TEMPLATE_FIRST;
	always_comb begin
		case (tpl_idx[3:0])
			4'd0: tpl_octet = 8'h08;  // EtherType ARP
			4'd1: tpl_octet = 8'h06;
			4'd2: tpl_octet = 8'h00;  // Hardware Ethernet
			4'd3: tpl_octet = 8'h01;
			4'd4: tpl_octet = 8'h08;  // Protocol IPv4
			4'd5: tpl_octet = 8'h00;
			4'd6: tpl_octet = 8'h06;  // Address lengths
			4'd7: tpl_octet = 8'h04;
			4'd8: tpl_octet = 8'h00;  // Opcode request
			4'd9: tpl_octet = 8'h01;
			default: tpl_octet = 8'h00;
		endcase
	end

	// Accumulating pass flags
	// Reloaded at index 0, cleared by any mismatch
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			uc_ok       <= 1'b0;
			bc_ok       <= 1'b0;
			tpl_ok      <= 1'b0;
			tip_ok      <= 1'b0;
			tip_seen    <= 1'b0;
			src_unicast <= 1'b0;
		end else if (rx_valid) begin
			if (rx_first) begin
				uc_ok       <= cfg_hit;
				bc_ok       <= rx_data == BCAST_OCTET;
				tpl_ok      <= 1'b1;
				tip_ok      <= 1'b1;
				tip_seen    <= 1'b0;
				src_unicast <= 1'b0;
			end else begin
				if (in_mac && !cfg_hit)
					uc_ok <= 1'b0;
				if (in_mac && rx_data != BCAST_OCTET)
					bc_ok <= 1'b0;
				if (in_tpl && rx_data != tpl_octet)
					tpl_ok <= 1'b0;
				if (in_tip && !cfg_hit)
					tip_ok <= 1'b0;
				// Frame must reach the end of the target IP
				if (rx_cnt == ARP_TIP_FIRST + ARP_TIP_LEN - 1'b1)
					tip_seen <= 1'b1;
				// Group bit of the source MAC
				if (rx_cnt == SRC_MAC_FIRST)
					src_unicast <= ~rx_data[0];
			end
		end
	end

	assign mac_match = uc_ok | bc_ok;
	assign arp_ok = tpl_ok & tip_ok & tip_seen;

endmodule

/* crc32_check.sv */
// ================================================
// Ethernet CRC32 checker. Runs a bytewise reflected
// CRC over every frame octet including the FCS and
// flags the good residue.
// ================================================
`timescale 1ns/100ps

module crc32_check
	import arp_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  octet_t rx_data,
	input  logic   rx_valid,
	input  logic   rx_first,
	output logic   crc_ok
);

	logic [31:0] crc;
	logic [31:0] crc_base;

	// One octet through the reflected polynomial, LSB first
	function automatic logic [31:0] crc_octet(input logic [31:0] c, input octet_t d);
		logic [31:0] r;
		r = c ^ {24'd0, d};
		for (int i = 0; i < 8; i++) begin
			if (r[0])
				r = (r >> 1) ^ CRC_POLY;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	// Preset to all ones at the start of each frame
	assign crc_base = rx_first ? 32'hffffffff : crc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			crc <= 32'hffffffff;
		else if (rx_valid)
			crc <= crc_octet(crc_base, rx_data);
	end

	// FCS included, so a clean frame leaves the fixed residue
	assign crc_ok = crc == CRC_RESIDUE;

endmodule

/* arp_verdict.sv */
// ================================================
// Verdict stage. Latches the checker results and
// frame length at frame end, then pulses
// status_valid for one cycle.
// ================================================
`timescale 1ns/100ps

module arp_verdict
	import arp_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       rx_end,
	input  frame_cnt_t rx_cnt,
	input  logic       mac_match,
	input  logic       arp_ok,
	input  logic       src_unicast,
	input  logic       crc_ok,
	output logic       status_valid,
	output status_t    status_vec,
	output frame_cnt_t pack_len
);

	status_t status_n;
	logic    end_d;

	// Accepted needs every check at once
	always_comb begin
		status_n = '0;
		status_n[STAT_CRC] = crc_ok;
		status_n[STAT_MAC] = mac_match;
		status_n[STAT_ARP] = arp_ok;
		status_n[STAT_ACCEPT] = crc_ok & mac_match & arp_ok & src_unicast;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			status_vec   <= '0;
			pack_len     <= '0;
			end_d        <= 1'b0;
			status_valid <= 1'b0;
		end else begin
			// rx_cnt still holds the last index here
			if (rx_end) begin
				status_vec <= status_n;
				pack_len   <= rx_cnt + 1'b1;
			end
			end_d        <= rx_end;
			status_valid <= end_d;
		end
	end

endmodule

/* arp_scanner.sv */
// ================================================
// ARP request scanner top level. Front end feeds
// header match and CRC check side by side, verdict
// reports one status per completed frame.
// ================================================
`timescale 1ns/100ps

module arp_scanner
	import arp_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  octet_t     eth_in,
	input  logic       eth_in_s,
	input  logic       enable_rx,
	output cfg_addr_t  cfg_addr,
	input  octet_t     cfg_data,
	output logic       status_valid,
	output status_t    status_vec,
	output frame_cnt_t pack_len
);

	// Registered octet stream
	octet_t     rx_data;
	logic       rx_valid;
	logic       rx_first;
	frame_cnt_t rx_cnt;
	logic       rx_end;
	// Checker results
	logic       mac_match;
	logic       arp_ok;
	logic       src_unicast;
	logic       crc_ok;

	frame_sync u_sync (
		.clk(clk), .arst_n(arst_n),
		.eth_in(eth_in), .eth_in_s(eth_in_s), .enable_rx(enable_rx),
		.rx_data(rx_data), .rx_valid(rx_valid), .rx_first(rx_first),
		.rx_cnt(rx_cnt), .rx_end(rx_end)
	);

	arp_header_check u_hdr (
		.clk(clk), .arst_n(arst_n),
		.rx_data(rx_data), .rx_valid(rx_valid), .rx_first(rx_first), .rx_cnt(rx_cnt),
		.cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.mac_match(mac_match), .arp_ok(arp_ok), .src_unicast(src_unicast)
	);

	crc32_check u_crc (
		.clk(clk), .arst_n(arst_n),
		.rx_data(rx_data), .rx_valid(rx_valid), .rx_first(rx_first),
		.crc_ok(crc_ok)
	);

	arp_verdict u_verdict (
		.clk(clk), .arst_n(arst_n),
		.rx_end(rx_end), .rx_cnt(rx_cnt),
		.mac_match(mac_match), .arp_ok(arp_ok), .src_unicast(src_unicast), .crc_ok(crc_ok),
		.status_valid(status_valid), .status_vec(status_vec), .pack_len(pack_len)
	);

endmodule

/* tb_clock.sv */
// ================================================
// Testbench clock and reset source. 8 ns clock,
// arst_n held low for the first 10 rising edges.
// ================================================
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic arst_n
);

	localparam int HALF_PERIOD = 4;
	localparam logic [3:0] RESET_CYCLES = 4'd10;

	logic [3:0] rst_left = RESET_CYCLES;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Reset counts down on rising edges, then stays released
	always @(posedge clk) begin
		if (rst_left != 4'd0)
			rst_left <= rst_left - 4'd1;
	end

	assign arst_n = rst_left == 4'd0;

endmodule

/* arp_scanner_assert.sv */
// ================================================
// Concurrent checks on the scanner outputs. Bound to
// the top level from the testbench.
// ================================================
`timescale 1ns/100ps

module arp_scanner_assert
	import arp_pkg::*;
(
	input logic       clk,
	input logic       arst_n,
	input logic       eth_in_s,
	input logic       status_valid,
	input frame_cnt_t pack_len
);

	// Report pulse is exactly one cycle wide
	single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		status_valid |=> !status_valid)
		else $error("status_valid stayed high for two cycles");

	// Reports only come out in the gap between frames
	report_in_gap: assert property (@(posedge clk) disable iff (!arst_n)
		status_valid |-> !eth_in_s)
		else $error("status_valid high while eth_in_s is high");

	// Padded frames with FCS are never shorter than 64 octets
	min_length: assert property (@(posedge clk) disable iff (!arst_n)
		status_valid |-> (pack_len >= 11'd64))
		else $error("pack_len below 64 with status_valid high");

endmodule

/* arp_scanner_tb.sv */
// ================================================
// Testbench for the ARP scanner. Builds frames from
// a table, drives them on GMII octet by octet and
// checks each status report, its timing and length.
// ================================================
`timescale 1ns/100ps

module arp_scanner_tb
	import arp_pkg::*;
();

	localparam logic [47:0] OUR_MAC = 48'h02_1b_3c_4d_5e_6f;
	localparam logic [47:0] PEER_MAC = 48'h02_a0_b1_c2_d3_e4;
	localparam logic [31:0] OUR_IP = 32'hc0_a8_0a_07;
	localparam logic [31:0] PEER_IP = 32'hc0_a8_0a_21;
	// Falling edges counted from the strobe drop to the sampled report
	localparam int LATENCY = 4;
	localparam int REPORT_TIMEOUT = 60;
	localparam int NUM_TESTS = 11;

	// Destination kinds
	localparam int D_OURS = 0;
	localparam int D_BCAST = 1;
	localparam int D_WRONG = 2;
	// Corruptions
	localparam int C_NONE = 0;
	localparam int C_FCS = 1;
	localparam int C_TIP = 2;
	localparam int C_OPCODE = 3;
	localparam int C_SRC_MC = 4;
	localparam int C_PREAMBLE = 5;

	// One table row
	// A report of 0 means the frame must be dropped
	typedef struct packed {
		int dst;
		int corrupt;
		int gap;
		int en;
		int frames;
		int len;
		int report;
		int exp;
	} test_t;

	logic       clk;
	logic       arst_n;
	octet_t     eth_in = 8'h00;
	logic       eth_in_s = 1'b0;
	logic       enable_rx = 1'b0;
	cfg_addr_t  cfg_addr;
	octet_t     cfg_data = 8'h00;
	logic       status_valid;
	status_t    status_vec;
	frame_cnt_t pack_len;

	octet_t     cfg_mem [16];
	octet_t     fq [$];
	test_t      tests [NUM_TESTS];
	// Report log filled on falling edges
	int         cyc = 0;
	int         st_cyc [$];
	status_t    st_vec [$];
	frame_cnt_t st_len [$];
	int         fall_cyc [$];
	int         rep_base = 0;
	int         errors = 0;

	tb_clock u_clock (.clk(clk), .arst_n(arst_n));

	arp_scanner UUT (
		.clk(clk), .arst_n(arst_n),
		.eth_in(eth_in), .eth_in_s(eth_in_s), .enable_rx(enable_rx),
		.cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.status_valid(status_valid), .status_vec(status_vec), .pack_len(pack_len)
	);

	bind arp_scanner arp_scanner_assert u_assert (
		.clk(clk), .arst_n(arst_n), .eth_in_s(eth_in_s),
		.status_valid(status_valid), .pack_len(pack_len)
	);

	// Config memory with one cycle read latency
	always @(posedge clk)
		cfg_data <= cfg_mem[cfg_addr];

	// Outputs are sampled mid-cycle
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (status_valid) begin
			st_cyc.push_back(cyc);
			st_vec.push_back(status_vec);
			st_len.push_back(pack_len);
		end
	end

	// Pushes the low n octets of v with the most significant first
	task automatic push_octets(input logic [47:0] v, input int n);
		int k;
		for (k = n - 1; k >= 0; k--)
			fq.push_back(v[8*k +: 8]);
	endtask

	// Bit-serial CRC32 with the normal polynomial and data taken LSB first
	function automatic logic [31:0] ethernet_fcs();
		logic [31:0] c;
		logic [31:0] r;
		logic        fb;
		int          i;
		int          b;
		c = 32'hffffffff;
		for (i = 0; i < fq.size(); i++) begin
			for (b = 0; b < 8; b++) begin
				fb = c[31] ^ fq[i][b];
				c = {c[30:0], 1'b0};
				if (fb)
					c = c ^ 32'h04c11db7;
			end
		end
		// Register is mirrored and complemented, then sent low octet first
		for (b = 0; b < 32; b++)
			r[b] = c[31-b];
		return ~r;
	endfunction

	// Ethernet header, ARP body, random padding and FCS
	task automatic build_frame(input test_t t);
		logic [47:0] dst;
		logic [47:0] src;
		logic [31:0] fcs;
		int          k;
		fq.delete();
		case (t.dst)
			D_BCAST: dst = 48'hffff_ffff_ffff;
			D_WRONG: dst = OUR_MAC ^ 48'h1;
			default: dst = OUR_MAC;
		endcase
		src = PEER_MAC;
		if (t.corrupt == C_SRC_MC)
			src = src | 48'h01_00_00_00_00_00;
		push_octets(dst, 6);
		push_octets(src, 6);
		push_octets(48'h0806, 2);
		push_octets(48'h0001, 2);
		push_octets(48'h0800, 2);
		push_octets(48'h0604, 2);
		push_octets((t.corrupt == C_OPCODE) ? 48'h0002 : 48'h0001, 2);
		push_octets(src, 6);
		push_octets({16'h0, PEER_IP}, 4);
		push_octets(48'h0, 6);
		push_octets({16'h0, (t.corrupt == C_TIP) ? (OUR_IP ^ 32'h1) : OUR_IP}, 4);
		while (fq.size() < t.len)
			fq.push_back(octet_t'($urandom));
		fcs = ethernet_fcs();
		if (t.corrupt == C_FCS)
			fcs = fcs ^ 32'h0000_0100;
		for (k = 0; k < 4; k++)
			fq.push_back(fcs[8*k +: 8]);
	endtask

	task automatic drive_octet(input octet_t v);
		@(posedge clk);
		eth_in   <= v;
		eth_in_s <= 1'b1;
	endtask

	task automatic end_strobe();
		@(posedge clk);
		eth_in_s <= 1'b0;
		eth_in   <= 8'h00;
	endtask

	task automatic set_enable(input logic en);
		@(posedge clk);
		enable_rx <= en;
	endtask

	// Preamble, SFD and the built frame followed by strobe low
	task automatic send_frame(input logic bad_pre);
		int p;
		for (p = 0; p < 7; p++)
			drive_octet((bad_pre && p == 3) ? 8'h54 : PREAMBLE_OCTET);
		drive_octet(SFD_OCTET);
		for (p = 0; p < fq.size(); p++)
			drive_octet(fq[p]);
		end_strobe();
		fall_cyc.push_back(cyc);
	endtask

	// Short junk burst that the scanner drops and that restarts its gap count
	task automatic flush_line();
		drive_octet(8'h00);
		drive_octet(8'h00);
		end_strobe();
	endtask

	// The strobe edge itself gives the first low cycle
	task automatic hold_gap(input int n);
		repeat (n - 1) @(posedge clk);
	endtask

	task automatic wait_reports(input int n, output logic timed_out);
		int k;
		k = 0;
		while (k < REPORT_TIMEOUT && (n == 0 || st_cyc.size() - rep_base < n)) begin
			@(posedge clk);
			k++;
		end
		timed_out = (st_cyc.size() - rep_base) < n;
	endtask

	initial begin
		int     i;
		int     j;
		int     r;
		int     f;
		int     k;
		int     errs_before;
		int     fall_base;
		int     passed;
		int     failed;
		logic   timed_out;
		test_t  t;
		void'($urandom(32'h45aa674f));
		passed = 0;
		failed = 0;
		// Unused words get an address pattern, then MAC and IP on top
		for (k = 0; k < 16; k++)
			cfg_mem[k] = 8'hc0 | 8'(k);
		for (k = 0; k < 6; k++)
			cfg_mem[k] = OUR_MAC[47-8*k -: 8];
		for (k = 0; k < 4; k++)
			cfg_mem[6+k] = OUR_IP[31-8*k -: 8];

		tests[0]  = '{D_OURS, C_NONE, 12, 1, 1, 60, 1, 4'b1111};
		tests[1]  = '{D_BCAST, C_NONE, 12, 1, 1, 64, 1, 4'b1111};
		tests[2]  = '{D_OURS, C_FCS, 12, 1, 1, 60, 1, 4'b0110};
		tests[3]  = '{D_OURS, C_TIP, 12, 1, 1, 60, 1, 4'b0011};
		tests[4]  = '{D_OURS, C_OPCODE, 12, 1, 1, 60, 1, 4'b0011};
		tests[5]  = '{D_WRONG, C_NONE, 12, 1, 1, 60, 1, 4'b0101};
		tests[6]  = '{D_OURS, C_SRC_MC, 12, 1, 1, 60, 1, 4'b0111};
		tests[7]  = '{D_OURS, C_PREAMBLE, 12, 1, 1, 60, 0, 4'b0000};
		tests[8]  = '{D_OURS, C_NONE, 5, 1, 1, 60, 0, 4'b0000};
		tests[9]  = '{D_OURS, C_NONE, 12, 0, 1, 60, 0, 4'b0000};
		tests[10] = '{D_OURS, C_NONE, 12, 1, 2, 70, 1, 4'b1111};

		k = 0;
		while (arst_n !== 1'b1 && k < 40) begin
			@(negedge clk);
			k++;
		end
		if (arst_n !== 1'b1) begin
			$display("Reset was never released");
			errors++;
		end
		@(negedge clk);
		if (status_valid != 1'b0) begin
			$display("Error: %0t status_valid expected 0 got %b", $time, status_valid);
			errors++;
		end
		if (status_vec != 4'd0) begin
			$display("Error: %0t status_vec expected 0000 got %b", $time, status_vec);
			errors++;
		end
		if (pack_len != 11'd0) begin
			$display("Error: %0t pack_len expected 0 got %0d", $time, pack_len);
			errors++;
		end

		for (i = 0; i < NUM_TESTS; i++) begin
			t = tests[i];
			errs_before = errors;
			rep_base = st_cyc.size();
			fall_base = fall_cyc.size();
			set_enable(t.en[0]);
			build_frame(t);
			flush_line();
			hold_gap(t.gap);
			send_frame(t.corrupt == C_PREAMBLE);
			// Back to back frame repeats the first one after the same gap
			if (t.frames == 2) begin
				hold_gap(t.gap);
				send_frame(1'b0);
			end
			wait_reports((t.report != 0) ? t.frames : 0, timed_out);

			if (t.report == 0) begin
				if (st_cyc.size() != rep_base) begin
					$display("Error: %0t status_valid expected 0 got 1", $time);
					errors++;
				end
			end else if (timed_out) begin
				$display("Test %0d got no status_valid within %0d cycles", i, REPORT_TIMEOUT);
				errors++;
			end else begin
				for (j = 0; j < t.frames; j++) begin
					r = rep_base + j;
					f = fall_base + j;
					if (st_vec[r] != t.exp[3:0]) begin
						$display("Error: %0t status_vec expected %b got %b",
							$time, t.exp[3:0], st_vec[r]);
						errors++;
					end
					if (int'(st_len[r]) != t.len + 4) begin
						$display("Error: %0t pack_len expected %0d got %0d",
							$time, t.len + 4, st_len[r]);
						errors++;
					end
					if (st_cyc[r] != fall_cyc[f] + LATENCY) begin
						$display("Error: %0t status_valid cycle expected %0d got %0d",
							$time, fall_cyc[f] + LATENCY, st_cyc[r]);
						errors++;
					end
				end
			end

			if (errors == errs_before) begin
				passed++;
				$display("Test %0d passed", i);
			end else begin
				failed++;
				$display("Test %0d failed", i);
			end
		end

		$display("Tests %0d, passed %0d, failed %0d, errors %0d",
			NUM_TESTS, passed, failed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* arp_scanner.f */
arp_pkg.sv
frame_sync.sv
arp_header_check.sv
crc32_check.sv
arp_verdict.sv
arp_scanner.sv
tb_clock.sv
arp_scanner_assert.sv
arp_scanner_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= arp_scanner_tb
FILELIST  ?= arp_scanner.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
